/* Bender.yml */
package:
  name: det_accel

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/detPkg.sv
      - verilog/matrixRam.sv
      - verilog/sdramLoader.sv
      - verilog/fixMul.sv
      - verilog/fixDiv.sv
      - verilog/luEngine.sv
      - verilog/cmdCtrl.sv
      - verilog/detTop.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - dv/sdramSlave.sv
      - dv/tbDet.sv

/* detTop.f */
+incdir+verilog
verilog/detPkg.sv
verilog/matrixRam.sv
verilog/sdramLoader.sv
verilog/fixMul.sv
verilog/fixDiv.sv
verilog/luEngine.sv
verilog/cmdCtrl.sv
verilog/detTop.sv
dv/sdramSlave.sv
dv/tbDet.sv

/* dv/sdramSlave.sv */
// SDRAM slave model with random waitrequest, in-order random read latency and read counters
`timescale 1ns/1ps
`default_nettype none

`include "det_defines.svh"

module sdramSlave
    import detPkg::*;
#(
    parameter int MemWords = 4096
) (
    input  logic     clk,
    input  avmReq_t  avm,
    output avmResp_t avmRsp,
    input  int       waitPct  // chance of waitrequest per cycle, in percent
);

    logic [`DET_WORD_W-1:0] mem [0:MemWords-1];
    int                     readCnt [0:MemWords-1];  // accepted reads per word
    int                     acceptTotal;
    int                     cyc;
    int                     lastDue;
    int                     pendIdx [$];  // word index of reads in flight
    int                     pendDue [$];  // cycle on which each one returns

    initial begin : model
        int wordIdx;
        int due;
        avmRsp      = '0;
        cyc         = 0;
        lastDue     = 0;
        acceptTotal = 0;
        // background pattern built from the whole word address
        for (int w = 0; w < MemWords; w++) begin
            mem[w]     = (32'(w) * 32'h9e37_79b1) ^ {16'(w), ~16'(w)};
            readCnt[w] = 0;
        end
        forever begin
            @(negedge clk);
            cyc++;
            // return side, one word per cycle in request order
            avmRsp.readdatavalid = 1'b0;
            avmRsp.readdata      = '0;
            if (pendDue.size() > 0 && pendDue[0] <= cyc) begin
                wordIdx              = pendIdx.pop_front();
                due                  = pendDue.pop_front();
                avmRsp.readdatavalid = 1'b1;
                avmRsp.readdata      = mem[wordIdx];
            end
            // request side, accepted on the next rising edge unless stalled
            avmRsp.waitrequest = (($urandom % 100) < waitPct);
            if (avm.read && !avmRsp.waitrequest) begin
                wordIdx = int'(avm.address[`DET_BUS_ADDR_W-1:2]) % MemWords;
                readCnt[wordIdx]++;
                acceptTotal++;
                due = cyc + 1 + int'($urandom % 6);  // 1 to 6 cycles
                if (due <= lastDue) begin
                    due = lastDue + 1;  // keep returns in order
                end
                lastDue = due;
                pendIdx.push_back(wordIdx);
                pendDue.push_back(due);
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tbDet.sv */
// testbench for detTop with SDRAM model, Q16.16 Doolittle reference model, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "det_defines.svh"

module tbDet
    import detPkg::*;
();

    localparam int     MemWords     = 4096;
    localparam longint BigRunCycles = 32 * 32 * 32 * 8;  // loose bound for one 32x32 run
    localparam longint WatchdogNs   = BigRunCycles * 8 * 19;  // about 40 ms

    logic                   clk;
    logic                   arstN;
    cmdReq_t                cmd;
    cmdResp_t               resp;
    avmReq_t                avm;
    avmResp_t               avmRsp;
    logic                   resultRead;
    logic [`DET_WORD_W-1:0] resultReadData;
    logic                   irq;
    int                     waitPct;

    int                     errCount;
    int                     checkCount;
    int                     testCount;
    logic [`DET_WORD_W-1:0] mat [0:`DET_MAX_DIM*`DET_MAX_DIM-1];  // row-major test matrix

    detTop dut0 (
        .clk            (clk),
        .arstN          (arstN),
        .cmd            (cmd),
        .resp           (resp),
        .avm            (avm),
        .avmRsp         (avmRsp),
        .resultRead     (resultRead),
        .resultReadData (resultReadData),
        .irq            (irq)
    );

    sdramSlave #(.MemWords(MemWords)) slave0 (
        .clk     (clk),
        .avm     (avm),
        .avmRsp  (avmRsp),
        .waitPct (waitPct)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(WatchdogNs);
        $display("watchdog expired: the tests did not finish in the expected time");
        $display("TESTS FAILED");
        $finish;
    end

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("error at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic finishTest(input string name, input int errsAtStart);
        testCount++;
        $display("test %-28s %s", name, (errCount == errsAtStart) ? "ok" : "mismatches");
    endtask

    // Q16.16 product from an arithmetic shift of the full 64-bit product
    function automatic logic [31:0] fxMul(input logic [31:0] a, input logic [31:0] b);
        longint prod;
        prod = longint'($signed(a)) * longint'($signed(b));
        return 32'(prod >>> `DET_FRAC_BITS);
    endfunction

    // Q16.16 quotient truncated toward zero
    function automatic logic [31:0] fxDiv(input logic [31:0] num, input logic [31:0] den);
        longint n;
        longint d;
        n = longint'($signed(num)) <<< `DET_FRAC_BITS;
        d = longint'($signed(den));
        return 32'(n / d);
    endfunction

    // row-by-row Doolittle in place followed by the diagonal product
    function automatic logic [31:0] modelDet(input int n);
        logic [31:0] a [0:`DET_MAX_DIM*`DET_MAX_DIM-1];
        logic [31:0] acc;
        logic [31:0] d;
        int          lim;
        for (int x = 0; x < n * n; x++) begin
            a[x] = mat[x];
        end
        for (int i = 0; i < n; i++) begin
            for (int j = 0; j < n; j++) begin
                acc = a[i*n+j];
                lim = (j < i) ? j : i;
                for (int p = 0; p < lim; p++) begin
                    acc = acc - fxMul(a[i*n+p], a[p*n+j]);
                end
                if (j < i) begin
                    if (a[j*n+j] == 32'd0) begin
                        return `DET_PIVOT_FAIL;
                    end
                    acc = fxDiv(acc, a[j*n+j]);
                end
                a[i*n+j] = acc;
            end
        end
        d = `DET_ONE;
        for (int k = 0; k < n; k++) begin
            d = fxMul(d, a[k*n+k]);
        end
        return d;
    endfunction

    function automatic int runLimit(input int n);
        return n * n * n * 8 + n * n * 100 + 1000;
    endfunction

    // small entries with whole part -4 to 4 plus a random fraction
    task automatic fillRandom(input int n);
        int whole;
        for (int x = 0; x < n * n; x++) begin
            whole  = int'($urandom % 9) - 4;
            mat[x] = 32'(whole <<< `DET_FRAC_BITS) + ($urandom % 65536);
        end
    endtask

    // called and returning on a falling edge
    task automatic sendCmd(input logic [31:0] addr, input logic [31:0] dim,
                           output logic [31:0] code);
        cmd.start = 1'b1;
        cmd.dataa = addr;
        cmd.datab = dim;
        @(negedge clk);
        cmd.start = 1'b0;
        code      = resp.result;
        checkEq(32'(resp.done), 32'd1, "done one cycle after start");
        @(negedge clk);
        checkEq(32'(resp.done), 32'd0, "done still high two cycles after start");
    endtask

    task automatic readResult(output logic [31:0] value);
        resultRead = 1'b1;
        @(negedge clk);
        resultRead = 1'b0;
        value      = resultReadData;
    endtask

    task automatic invalidStarts();
        logic [31:0] dims [0:4];
        logic [31:0] code;
        logic        sawRead;
        int          acceptBase;
        dims[0]    = 32'd0;
        dims[1]    = 32'd1;
        dims[2]    = 32'd33;
        dims[3]    = 32'd66;  // low bits alone would look like 2
        dims[4]    = 32'h8000_0004;
        waitPct    = 20;
        sawRead    = 1'b0;
        acceptBase = slave0.acceptTotal;
        for (int d = 0; d < 5; d++) begin
            sendCmd(32'h0000_0200, dims[d], code);
            checkEq(code, `ST_READY, $sformatf("start with dimension %0d", dims[d]));
        end
        repeat (20) begin
            @(negedge clk);
            sawRead = sawRead | avm.read;
        end
        checkEq(32'(sawRead), 32'd0, "SDRAM read after rejected starts");
        checkEq(32'(slave0.acceptTotal - acceptBase), 32'd0, "reads accepted after rejects");
    endtask

    task automatic runDet(input int n, input int pct, input string label,
                          output logic [31:0] result);
        int          wordBase;
        int          acceptBase;
        int          left;
        int          pollTimer;
        int          polls;
        logic        busyOk;
        logic [31:0] code;
        logic [31:0] expected;
        expected = modelDet(n);
        wordBase = $urandom % (MemWords - `DET_MAX_DIM * `DET_MAX_DIM);
        for (int w = 0; w < MemWords; w++) begin
            slave0.readCnt[w] = 0;
        end
        for (int x = 0; x < n * n; x++) begin
            slave0.mem[wordBase+x] = mat[x];
        end
        acceptBase = slave0.acceptTotal;
        waitPct    = pct;
        result     = '1;
        sendCmd(32'(wordBase * 4), 32'(n), code);
        checkEq(code, `ST_ACCEPT, $sformatf("%s start code", label));
        left      = runLimit(n);
        pollTimer = 0;
        polls     = 0;
        while (!irq && left > 0) begin
            if (pollTimer == 0) begin
                // another start while busy gets a busy code
                sendCmd(32'h0000_0100, 32'(n), code);
                if (polls == 0) begin
                    // right after the accept the load cannot have finished
                    checkEq(code, `ST_LOADING, $sformatf("%s first busy poll", label));
                end else begin
                    busyOk = (code == `ST_LOADING) || (code == `ST_CALC);
                    checkEq(32'(busyOk), 32'd1,
                            $sformatf("%s busy poll answered %0d", label, code));
                end
                polls++;
                pollTimer = 256;
            end else begin
                @(negedge clk);
                pollTimer--;
            end
            left--;
        end
        if (!irq) begin
            errCount++;
            $display("%s: irq did not rise within %0d cycles", label, runLimit(n));
        end else begin
            sendCmd(32'h0, 32'h0, code);
            checkEq(code, `ST_WAITING, $sformatf("%s poll after irq", label));
            readResult(result);
            checkEq(result, expected, $sformatf("%s determinant", label));
            checkEq(32'(irq), 32'd0, $sformatf("%s irq after result read", label));
            checkEq(32'(slave0.acceptTotal - acceptBase), 32'(n * n),
                    $sformatf("%s accepted reads", label));
            for (int x = 0; x < n * n; x++) begin
                checkEq(32'(slave0.readCnt[wordBase+x]), 32'd1,
                        $sformatf("%s reads of word %0d", label, x));
            end
            sendCmd(32'h0, 32'h0, code);
            checkEq(code, `ST_READY, $sformatf("%s poll after result read", label));
        end
    endtask

    initial begin : main
        int          errs;
        int          n;
        logic [31:0] result;
        errCount   = 0;
        checkCount = 0;
        testCount  = 0;
        cmd        = '0;
        resultRead = 1'b0;
        waitPct    = 0;
        arstN      = 1'b0;
        void'($urandom(32'h111b));
        repeat (2) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);

        errs = errCount;
        invalidStarts();
        finishTest("invalid dimensions", errs);

        errs = errCount;
        for (int r = 0; r < 10; r++) begin
            n = 2 + int'($urandom % 7);
            fillRandom(n);
            runDet(n, 30, $sformatf("random %0dx%0d", n, n), result);
        end
        finishTest("status codes and small runs", errs);

        errs = errCount;
        for (int r = 0; r < 3; r++) begin
            n = 3 + int'($urandom % 6);
            fillRandom(n);
            mat[0] = 32'd0;  // a[0][0] is the first pivot
            runDet(n, 30, $sformatf("zero pivot %0dx%0d", n, n), result);
            checkEq(result, `DET_PIVOT_FAIL, "zero pivot sentinel");
        end
        finishTest("zero pivot", errs);

        errs = errCount;
        fillRandom(`DET_MAX_DIM);
        runDet(`DET_MAX_DIM, 85, "32x32 throttled", result);
        finishTest("32x32 with heavy waitrequest", errs);

        errs = errCount;
        fillRandom(3);
        runDet(3, 0, "rerun 3x3", result);
        finishTest("rerun without reset", errs);

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/cmdCtrl.sv */
// command port stage machine with status codes, interrupt and result register
`timescale 1ns/1ps
`default_nettype none

`include "det_defines.svh"

module cmdCtrl
    import detPkg::*;
(
    input  logic                       clk,
    input  logic                       arstN,
    input  cmdReq_t                    cmd,
    output cmdResp_t                   resp,
    output logic                       loadGo,
    output logic [`DET_BUS_ADDR_W-1:0] baseAddr,
    output logic [5:0]                 dimension,
    input  logic                       loadDone,
    input  logic                       calcDone,
    input  logic [`DET_WORD_W-1:0]     det,
    input  logic                       resultRead,
    output logic [`DET_WORD_W-1:0]     resultReadData,
    output logic                       irq
);

    typedef enum logic [1:0] {sIdle, sLoading, sCalc, sWaiting} stage_t;

    stage_t                 stage;
    logic                   validDim;
    logic                   accept;
    logic [`DET_WORD_W-1:0] code;
    logic [`DET_WORD_W-1:0] resultReg;

    assign validDim = (cmd.datab >= 32'd2) && (cmd.datab <= `DET_MAX_DIM);
    assign accept   = cmd.start && validDim && (stage == sIdle);

    always_comb begin
        case (stage)
            sIdle:    code = validDim ? `ST_ACCEPT : `ST_READY;
            sLoading: code = `ST_LOADING;
            sCalc:    code = `ST_CALC;
            default:  code = `ST_WAITING;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stage  <= sIdle;
            resp   <= '0;
            loadGo <= 1'b0;
            irq    <= 1'b0;
        end else begin
            resp.done   <= cmd.start;
            resp.result <= cmd.start ? code : '0;
            loadGo      <= accept;
            case (stage)
                sIdle:    if (accept) stage <= sLoading;
                sLoading: if (loadDone) stage <= sCalc;
                sCalc: begin
                    if (calcDone) begin
                        irq   <= 1'b1;
                        stage <= sWaiting;
                    end
                end
                default: begin
                    if (resultRead) begin  // service read releases the unit
                        irq   <= 1'b0;
                        stage <= sIdle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            baseAddr  <= cmd.dataa[`DET_BUS_ADDR_W-1:0];
            dimension <= cmd.datab[5:0];
        end
        if (stage == sCalc && calcDone) resultReg <= det;
        if (stage == sWaiting && resultRead) resultReadData <= resultReg;
    end

endmodule

`default_nettype wire

/* verilog/detPkg.sv */
// packed struct types for the command port, SDRAM master and matrix RAM ports
`default_nettype none

`include "det_defines.svh"

package detPkg;

    typedef struct packed {
        logic                   start;
        logic [`DET_WORD_W-1:0] dataa;  // byte base address
        logic [`DET_WORD_W-1:0] datab;  // dimension
    } cmdReq_t;

    typedef struct packed {
        logic                   done;
        logic [`DET_WORD_W-1:0] result;
    } cmdResp_t;

    typedef struct packed {
        logic                       read;
        logic [`DET_BUS_ADDR_W-1:0] address;
    } avmReq_t;

    typedef struct packed {
        logic [`DET_WORD_W-1:0] readdata;
        logic                   readdatavalid;
        logic                   waitrequest;
    } avmResp_t;

    typedef struct packed {
        logic                       en;
        logic [`DET_RAM_ADDR_W-1:0] addr;
        logic [`DET_WORD_W-1:0]     data;
    } ramWr_t;

    typedef struct packed {
        logic                       en;
        logic [`DET_RAM_ADDR_W-1:0] addr;
    } ramRd_t;

endpackage

`default_nettype wire

/* verilog/detTop.sv */
// determinant accelerator top with command control, SDRAM loader, matrix RAM and LU engine
`timescale 1ns/1ps
`default_nettype none

`include "det_defines.svh"

module detTop
    import detPkg::*;
(
    input  logic                   clk,
    input  logic                   arstN,
    input  cmdReq_t                cmd,
    output cmdResp_t               resp,
    output avmReq_t                avm,
    input  avmResp_t               avmRsp,
    input  logic                   resultRead,
    output logic [`DET_WORD_W-1:0] resultReadData,
    output logic                   irq
);

    logic                       loadGo;
    logic [`DET_BUS_ADDR_W-1:0] baseAddr;
    logic [5:0]                 dimension;
    logic                       loadDone;
    logic                       calcDone;
    logic [`DET_WORD_W-1:0]     det;
    logic [`DET_WORD_W-1:0]     ramData;
    ramWr_t                     loadWr;
    ramWr_t                     calcWr;
    ramRd_t                     calcRd;

    cmdCtrl cmdCtrl0 (
        .clk            (clk),
        .arstN          (arstN),
        .cmd            (cmd),
        .resp           (resp),
        .loadGo         (loadGo),
        .baseAddr       (baseAddr),
        .dimension      (dimension),
        .loadDone       (loadDone),
        .calcDone       (calcDone),
        .det            (det),
        .resultRead     (resultRead),
        .resultReadData (resultReadData),
        .irq            (irq)
    );

    sdramLoader sdramLoader0 (
        .clk       (clk),
        .arstN     (arstN),
        .loadGo    (loadGo),
        .baseAddr  (baseAddr),
        .dimension (dimension),
        .avm       (avm),
        .avmRsp    (avmRsp),
        .loadWr    (loadWr),
        .loadDone  (loadDone)
    );

    matrixRam matrixRam0 (
        .clk    (clk),
        .loadWr (loadWr),
        .calcWr (calcWr),
        .rd     (calcRd),
        .rdData (ramData)
    );

    luEngine luEngine0 (
        .clk       (clk),
        .arstN     (arstN),
        .loadDone  (loadDone),
        .dimension (dimension),
        .calcRd    (calcRd),
        .ramData   (ramData),
        .calcWr    (calcWr),
        .calcDone  (calcDone),
        .det       (det)
    );

endmodule

`default_nettype wire

/* verilog/det_defines.svh */
// matrix limits, Q16.16 format, arithmetic latencies, status codes and pivot sentinel
`ifndef DET_DEFINES_SVH
`define DET_DEFINES_SVH

`define DET_MAX_DIM      32
`define DET_RAM_ADDR_W   10
`define DET_WORD_W       32
`define DET_BUS_ADDR_W   24
`define DET_FRAC_BITS    16
`define DET_ONE          32'h0001_0000
`define DET_PIVOT_FAIL   32'h8000_0000
`define DET_MUL_LATENCY  3
`define DET_DIV_LATENCY  49

// status codes returned on the command port
`define ST_READY    32'd0
`define ST_ACCEPT   32'd99
`define ST_LOADING  32'd1
`define ST_CALC     32'd2
`define ST_WAITING  32'd3

`endif

/* verilog/fixDiv.sv */
// sequential restoring Q16.16 divider, one quotient bit per cycle
`timescale 1ns/1ps
`default_nettype none

`include "det_defines.svh"

module fixDiv (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   start,
    input  logic [`DET_WORD_W-1:0] num,
    input  logic [`DET_WORD_W-1:0] den,
    output logic [`DET_WORD_W-1:0] q,
    output logic                   valid
);

    localparam int DvdW = `DET_WORD_W + `DET_FRAC_BITS;

    logic [5:0]             bitCnt;
    logic [DvdW-1:0]        dvd;      // dividend out at the top, quotient in at the bottom
    logic [`DET_WORD_W-1:0] rem;
    logic [`DET_WORD_W-1:0] divisor;
    logic                   neg;
    logic [`DET_WORD_W:0]   remShift;
    logic [`DET_WORD_W:0]   diff;
    logic                   qBit;
    logic [DvdW-1:0]        dvdNext;

    assign remShift = {rem, dvd[DvdW-1]};
    assign diff     = remShift - {1'b0, divisor};
    assign qBit     = !diff[`DET_WORD_W];  // no borrow
    assign dvdNext  = {dvd[DvdW-2:0], qBit};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bitCnt <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= 1'b0;
            if (start) begin
                bitCnt <= 6'(`DET_DIV_LATENCY - 1);
            end else if (bitCnt != 6'd0) begin
                bitCnt <= bitCnt - 6'd1;
                valid  <= (bitCnt == 6'd1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            dvd     <= {(num[`DET_WORD_W-1] ? -num : num), {`DET_FRAC_BITS{1'b0}}};
            rem     <= '0;
            divisor <= den[`DET_WORD_W-1] ? -den : den;
            neg     <= num[`DET_WORD_W-1] ^ den[`DET_WORD_W-1];
        end else if (bitCnt != 6'd0) begin
            dvd <= dvdNext;
            rem <= qBit ? diff[`DET_WORD_W-1:0] : remShift[`DET_WORD_W-1:0];
            if (bitCnt == 6'd1) begin
                // magnitude quotient, sign restored, truncated toward zero
                q <= neg ? -dvdNext[`DET_WORD_W-1:0] : dvdNext[`DET_WORD_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/fixMul.sv */
// three-stage signed Q16.16 multiplier
`timescale 1ns/1ps
`default_nettype none

`include "det_defines.svh"

module fixMul (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`DET_WORD_W-1:0] a,
    input  logic [`DET_WORD_W-1:0] b,
    output logic [`DET_WORD_W-1:0] p
);

    logic signed [`DET_WORD_W-1:0]   aR;
    logic signed [`DET_WORD_W-1:0]   bR;
    logic signed [2*`DET_WORD_W-1:0] prod;
    logic signed [2*`DET_WORD_W-1:0] prodShift;

    assign prodShift = prod >>> `DET_FRAC_BITS;  // keeps the sign

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            aR   <= '0;
            bR   <= '0;
            prod <= '0;
            p    <= '0;
        end else begin
            aR   <= a;
            bR   <= b;
            prod <= aR * bR;
            p    <= prodShift[`DET_WORD_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* verilog/luEngine.sv */
// Doolittle LU sequencer with row base table, zero-pivot abort and diagonal product
`timescale 1ns/1ps
`default_nettype none

`include "det_defines.svh"

module luEngine
    import detPkg::*;
(
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   loadDone,
    input  logic [5:0]             dimension,
    output ramRd_t                 calcRd,
    input  logic [`DET_WORD_W-1:0] ramData,
    output ramWr_t                 calcWr,
    output logic                   calcDone,
    output logic [`DET_WORD_W-1:0] det
);

    typedef enum logic [3:0] {
        sIdle, sInit, sElem, sGetAij, sPLoop, sRdB, sMul, sMulWait,
        sFinish, sPivot, sDivWait, sNext, sDiag, sDiagMul, sDiagWait
    } state_t;

    state_t                     state;
    logic [`DET_RAM_ADDR_W-1:0] rowBase [0:`DET_MAX_DIM-1];
    logic [`DET_RAM_ADDR_W-1:0] baseAcc;
    logic [5:0]                 i, j, p, k;
    logic [2:0]                 waitCnt;
    logic [`DET_WORD_W-1:0]     acc;  // running a[i][j]
    logic [`DET_WORD_W-1:0]     aip;
    logic [`DET_WORD_W-1:0]     mulA, mulP, divQ;
    logic                       divStart, divValid;
    logic                       below;
    logic [5:0]                 pLim;
    logic [5:0]                 last;

    assign below    = (j < i);          // L part, needs the pivot divide
    assign pLim     = below ? j : i;
    assign last     = dimension - 6'd1;
    assign mulA     = (state == sDiagMul) ? det : aip;
    assign divStart = (state == sPivot) && (ramData != '0);

    always_comb begin
        calcRd.en   = 1'b0;
        calcRd.addr = rowBase[i[4:0]] + 10'(j);  // a[i][j]
        case (state)
            sElem: calcRd.en = 1'b1;
            sPLoop: begin
                calcRd.en   = (p < pLim);
                calcRd.addr = rowBase[i[4:0]] + 10'(p);
            end
            sRdB: begin
                calcRd.en   = 1'b1;
                calcRd.addr = rowBase[p[4:0]] + 10'(j);
            end
            sFinish: begin
                calcRd.en   = below;  // pivot a[j][j]
                calcRd.addr = rowBase[j[4:0]] + 10'(j);
            end
            sDiag: begin
                calcRd.en   = (k != dimension);
                calcRd.addr = rowBase[k[4:0]] + 10'(k);
            end
            default: ;
        endcase
    end

    assign calcWr.en   = ((state == sFinish) && !below) || ((state == sDivWait) && divValid);
    assign calcWr.addr = rowBase[i[4:0]] + 10'(j);
    assign calcWr.data = below ? divQ : acc;

    // row base table, one entry per cycle after the load
    always_ff @(posedge clk) begin
        if (state == sInit) begin
            rowBase[i[4:0]] <= baseAcc;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= sIdle;
            i        <= '0;
            j        <= '0;
            p        <= '0;
            k        <= '0;
            baseAcc  <= '0;
            waitCnt  <= '0;
            acc      <= '0;
            aip      <= '0;
            det      <= '0;
            calcDone <= 1'b0;
        end else begin
            calcDone <= 1'b0;
            case (state)
                sIdle: begin
                    if (loadDone) begin
                        i       <= '0;
                        baseAcc <= '0;
                        state   <= sInit;
                    end
                end
                sInit: begin
                    baseAcc <= baseAcc + 10'(dimension);
                    if (i == last) begin
                        i     <= '0;
                        j     <= '0;
                        state <= sElem;
                    end else begin
                        i <= i + 6'd1;
                    end
                end
                sElem: state <= sGetAij;
                sGetAij: begin
                    acc   <= ramData;
                    p     <= '0;
                    state <= sPLoop;
                end
                sPLoop: state <= (p < pLim) ? sRdB : sFinish;
                sRdB: begin
                    aip   <= ramData;
                    state <= sMul;
                end
                sMul: begin  // a[p][j] on ramData into the multiplier
                    waitCnt <= 3'(`DET_MUL_LATENCY - 1);
                    state   <= sMulWait;
                end
                sMulWait: begin
                    if (waitCnt == 3'd0) begin
                        acc   <= acc - mulP;
                        p     <= p + 6'd1;
                        state <= sPLoop;
                    end else begin
                        waitCnt <= waitCnt - 3'd1;
                    end
                end
                sFinish: state <= below ? sPivot : sNext;
                sPivot: begin
                    if (ramData == '0) begin
                        det      <= `DET_PIVOT_FAIL;
                        calcDone <= 1'b1;
                        state    <= sIdle;
                    end else begin
                        state <= sDivWait;
                    end
                end
                sDivWait: if (divValid) state <= sNext;
                sNext: begin
                    if (j == last) begin
                        j <= '0;
                        if (i == last) begin
                            k     <= '0;
                            det   <= `DET_ONE;
                            state <= sDiag;
                        end else begin
                            i     <= i + 6'd1;
                            state <= sElem;
                        end
                    end else begin
                        j     <= j + 6'd1;
                        state <= sElem;
                    end
                end
                sDiag: begin
                    if (k == dimension) begin
                        calcDone <= 1'b1;
                        state    <= sIdle;
                    end else begin
                        state <= sDiagMul;
                    end
                end
                sDiagMul: begin
                    waitCnt <= 3'(`DET_MUL_LATENCY - 1);
                    state   <= sDiagWait;
                end
                sDiagWait: begin
                    if (waitCnt == 3'd0) begin
                        det   <= mulP;
                        k     <= k + 6'd1;
                        state <= sDiag;
                    end else begin
                        waitCnt <= waitCnt - 3'd1;
                    end
                end
                default: state <= sIdle;
            endcase
        end
    end

    fixMul mul0 (
        .clk   (clk),
        .arstN (arstN),
        .a     (mulA),
        .b     (ramData),
        .p     (mulP)
    );

    fixDiv div0 (
        .clk   (clk),
        .arstN (arstN),
        .start (divStart),
        .num   (acc),
        .den   (ramData),
        .q     (divQ),
        .valid (divValid)
    );

endmodule

`default_nettype wire

/* verilog/matrixRam.sv */
// matrix store with load and calculation write ports and a registered read port
`timescale 1ns/1ps
`default_nettype none

`include "det_defines.svh"

module matrixRam
    import detPkg::*;
(
    input  logic                   clk,
    input  ramWr_t                 loadWr,
    input  ramWr_t                 calcWr,
    input  ramRd_t                 rd,
    output logic [`DET_WORD_W-1:0] rdData
);

    logic [`DET_WORD_W-1:0] mem [0:(1 << `DET_RAM_ADDR_W)-1];

    always_ff @(posedge clk) begin
        if (loadWr.en) begin  // load port wins
            mem[loadWr.addr] <= loadWr.data;
        end else if (calcWr.en) begin
            mem[calcWr.addr] <= calcWr.data;
        end
        if (rd.en) begin
            rdData <= mem[rd.addr];
        end
    end

endmodule

`default_nettype wire

/* verilog/sdramLoader.sv */
// pipelined SDRAM read master streaming the row-major matrix into the matrix RAM
`timescale 1ns/1ps
`default_nettype none

`include "det_defines.svh"

module sdramLoader
    import detPkg::*;
(
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       loadGo,
    input  logic [`DET_BUS_ADDR_W-1:0] baseAddr,
    input  logic [5:0]                 dimension,
    output avmReq_t                    avm,
    input  avmResp_t                   avmRsp,
    output ramWr_t                     loadWr,
    output logic                       loadDone
);

    logic [10:0] total;   // dimension squared, up to 1024
    logic [10:0] reqCnt;  // requests accepted by the slave
    logic [10:0] wrCnt;   // words returned
    logic        active;
    logic        lastWr;

    assign total = 11'(dimension) * 11'(dimension);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            avm      <= '0;
            loadWr   <= '0;
            reqCnt   <= '0;
            wrCnt    <= '0;
            active   <= 1'b0;
            lastWr   <= 1'b0;
            loadDone <= 1'b0;
        end else begin
            loadWr.en <= 1'b0;
            lastWr    <= 1'b0;
            loadDone  <= lastWr;  // one cycle after the final RAM write
            if (loadGo) begin
                avm.read    <= 1'b1;
                avm.address <= baseAddr;
                reqCnt      <= '0;
                wrCnt       <= '0;
                active      <= 1'b1;
            end else begin
                // request side, held by waitrequest
                if (avm.read && !avmRsp.waitrequest) begin
                    avm.address <= avm.address + 24'd4;
                    reqCnt      <= reqCnt + 11'd1;
                    if (reqCnt == total - 11'd1) begin
                        avm.read <= 1'b0;
                    end
                end
                // return side, words arrive in order
                if (active && avmRsp.readdatavalid) begin
                    loadWr.en   <= 1'b1;
                    loadWr.addr <= wrCnt[`DET_RAM_ADDR_W-1:0];
                    loadWr.data <= avmRsp.readdata;
                    wrCnt       <= wrCnt + 11'd1;
                    if (wrCnt == total - 11'd1) begin
                        active <= 1'b0;
                        lastWr <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire
